// File: design/csc_cfg.svh
`ifndef CSC_CFG_SVH
`define CSC_CFG_SVH

`define SAMPLE_W       8           // Y, U, V samples and RGB channels
`define WORD_W         16
`define ADDR_W         18
`define ACC_W          32          // Signed accumulator
`define RGB_BASE       18'd146944  // First RGB word in SRAM

// Six-tap interpolation weights 21, -52, 159, 159, -52, 21
`define FIR_C0         21
`define FIR_C1         52
`define FIR_C2         159
`define FIR_ROUND      128
`define FIR_SHIFT      8

// Fixed-point colour conversion
`define Y_OFFSET       16
`define C_OFFSET       128
`define K_Y            76284
`define K_RV           104595
`define K_GU           25624
`define K_GV           53281
`define K_BU           132251
`define RGB_SHIFT      16          // Result byte position

`define FIFO_DEPTH     8           // In pixel pairs, power of two
`define MIN_LINE_PAIRS 4

`endif

// File: design/csc_pkg.sv
`default_nettype none

`include "csc_cfg.svh"

package csc_pkg;

    // One converted pixel pair, seen as channels or as SRAM words
    typedef union packed {
        struct packed {
            logic [`SAMPLE_W-1:0] r0;
            logic [`SAMPLE_W-1:0] g0;
            logic [`SAMPLE_W-1:0] b0;
            logic [`SAMPLE_W-1:0] r1;
            logic [`SAMPLE_W-1:0] g1;
            logic [`SAMPLE_W-1:0] b1;
        } pix;
        logic [2:0][`WORD_W-1:0] words; // Word 2 is {r0,g0}, word 0 is {g1,b1}
    } rgb_pair_u;

endpackage

`default_nettype wire

// File: design/chroma_upsampler.sv
`timescale 1ns/1ns
`default_nettype none

`include "csc_cfg.svh"

module chroma_upsampler (
    input  logic                       CLOCK_50_I,
    input  logic                       resetn,
    input  logic                       pair_strobe,
    input  logic                       line_first,
    input  logic                       line_last,
    input  logic [2*`SAMPLE_W-1:0]     y_pair,
    input  logic [`SAMPLE_W-1:0]       u_sample,
    input  logic [`SAMPLE_W-1:0]       v_sample,
    output logic                       up_valid,
    output logic [`SAMPLE_W-1:0]       y_even,
    output logic [`SAMPLE_W-1:0]       y_odd,
    output logic [`SAMPLE_W-1:0]       u_even,
    output logic signed [`ACC_W-1:0]   u_odd,
    output logic [`SAMPLE_W-1:0]       v_even,
    output logic signed [`ACC_W-1:0]   v_odd
);

    // Tap 0 is the oldest sample, tap 2 the centre
    logic [`SAMPLE_W-1:0]   u_tap [6];
    logic [`SAMPLE_W-1:0]   v_tap [6];
    logic [`SAMPLE_W-1:0]   u_nxt [6];
    logic [`SAMPLE_W-1:0]   v_nxt [6];
    // Y pairs line up with chroma taps 2 to 5
    logic [2*`SAMPLE_W-1:0] y_dly [4];
    logic [2*`SAMPLE_W-1:0] y_nxt [4];
    logic [2:0]             fill_cnt;
    logic [2:0]             fill_nxt;
    logic [1:0]             flush_cnt;
    logic [1:0]             y_pos;
    logic                   flushing;
    logic                   taps_full;

    function automatic logic signed [`ACC_W-1:0] fir6(input logic [`SAMPLE_W-1:0] t [6]);
        logic signed [`ACC_W-1:0] s [6];
        logic signed [`ACC_W-1:0] acc;
        for (int i = 0; i < 6; i++) begin
            s[i] = $signed({{(`ACC_W-`SAMPLE_W){1'b0}}, t[i]});
        end
        acc = `FIR_C0 * s[0] - `FIR_C1 * s[1] + `FIR_C2 * s[2]
            + `FIR_C2 * s[3] - `FIR_C1 * s[4] + `FIR_C0 * s[5] + `FIR_ROUND;
        return acc >>> `FIR_SHIFT;
    endfunction

    assign flushing = (flush_cnt != 2'd0);
    assign y_pos    = fill_cnt[1:0] + 2'd2; // Fill 3..5 maps to Y slot 1..3

    always_comb begin
        u_nxt    = u_tap;
        v_nxt    = v_tap;
        y_nxt    = y_dly;
        fill_nxt = fill_cnt;
        if (pair_strobe && line_first) begin
            // Replicate first chroma into the two older taps and the centre
            for (int i = 0; i < 3; i++) begin
                u_nxt[i] = u_sample;
                v_nxt[i] = v_sample;
            end
            y_nxt[0] = y_pair;
            fill_nxt = 3'd3;
        end else if (pair_strobe && fill_cnt < 3'd6) begin
            u_nxt[fill_cnt] = u_sample;
            v_nxt[fill_cnt] = v_sample;
            y_nxt[y_pos]    = y_pair;
            fill_nxt        = fill_cnt + 3'd1;
        end else if (pair_strobe || flushing) begin
            for (int i = 0; i < 5; i++) begin
                u_nxt[i] = u_tap[i+1];
                v_nxt[i] = v_tap[i+1];
            end
            for (int i = 0; i < 3; i++) begin
                y_nxt[i] = y_dly[i+1];
            end
            u_nxt[5] = pair_strobe ? u_sample : u_tap[5]; // Flush repeats the newest
            v_nxt[5] = pair_strobe ? v_sample : v_tap[5];
            y_nxt[3] = y_pair;
        end
    end

    assign taps_full = (fill_nxt == 3'd6) && (pair_strobe || flushing);

    always_ff @(posedge CLOCK_50_I or negedge resetn) begin
        if (!resetn) begin
            fill_cnt  <= 3'd0;
            flush_cnt <= 2'd0;
            up_valid  <= 1'b0;
        end else begin
            fill_cnt <= fill_nxt;
            if (pair_strobe && line_last) begin
                flush_cnt <= 2'd3; // Three pairs still sit in the window
            end else if (flushing) begin
                flush_cnt <= flush_cnt - 2'd1;
            end
            up_valid <= taps_full;
        end
    end

    always_ff @(posedge CLOCK_50_I) begin
        u_tap <= u_nxt;
        v_tap <= v_nxt;
        y_dly <= y_nxt;
        if (taps_full) begin
            y_even <= y_nxt[0][2*`SAMPLE_W-1:`SAMPLE_W];
            y_odd  <= y_nxt[0][`SAMPLE_W-1:0];
            u_even <= u_nxt[2];
            v_even <= v_nxt[2];
            u_odd  <= fir6(u_nxt);
            v_odd  <= fir6(v_nxt);
        end
    end

endmodule

`default_nettype wire

// File: design/yuv_to_rgb.sv
`timescale 1ns/1ns
`default_nettype none

`include "csc_cfg.svh"

module yuv_to_rgb
    import csc_pkg::*;
(
    input  logic                     CLOCK_50_I,
    input  logic                     resetn,
    input  logic                     up_valid,
    input  logic [`SAMPLE_W-1:0]     y_even,
    input  logic [`SAMPLE_W-1:0]     y_odd,
    input  logic [`SAMPLE_W-1:0]     u_even,
    input  logic signed [`ACC_W-1:0] u_odd,
    input  logic [`SAMPLE_W-1:0]     v_even,
    input  logic signed [`ACC_W-1:0] v_odd,
    output logic                     push,
    output rgb_pair_u                pair_in
);

    // Index 0 is the even pixel, 1 the odd one
    logic signed [`ACC_W-1:0] y_c [2];
    logic signed [`ACC_W-1:0] u_c [2];
    logic signed [`ACC_W-1:0] v_c [2];
    logic signed [`ACC_W-1:0] yk [2];
    logic signed [`ACC_W-1:0] rv [2];
    logic signed [`ACC_W-1:0] gu [2];
    logic signed [`ACC_W-1:0] gv [2];
    logic signed [`ACC_W-1:0] bu [2];
    logic [`SAMPLE_W-1:0]     r_ch [2];
    logic [`SAMPLE_W-1:0]     g_ch [2];
    logic [`SAMPLE_W-1:0]     b_ch [2];
    logic                     valid1;

    function automatic logic signed [`ACC_W-1:0] widen(input logic [`SAMPLE_W-1:0] s);
        return $signed({{(`ACC_W-`SAMPLE_W){1'b0}}, s});
    endfunction

    // Negative gives 0, overflow above the result byte gives 255
    function automatic logic [`SAMPLE_W-1:0] clip(input logic signed [`ACC_W-1:0] s);
        if (s[`ACC_W-1]) begin
            return '0;
        end else if (|s[`ACC_W-2:`RGB_SHIFT+`SAMPLE_W]) begin
            return '1;
        end else begin
            return s[`RGB_SHIFT +: `SAMPLE_W];
        end
    endfunction

    always_comb begin
        y_c[0] = widen(y_even) - `Y_OFFSET;
        y_c[1] = widen(y_odd) - `Y_OFFSET;
        u_c[0] = widen(u_even) - `C_OFFSET;
        u_c[1] = u_odd - `C_OFFSET;  // Filtered chroma may overshoot 0..255
        v_c[0] = widen(v_even) - `C_OFFSET;
        v_c[1] = v_odd - `C_OFFSET;
        for (int i = 0; i < 2; i++) begin
            r_ch[i] = clip(yk[i] + rv[i]);
            g_ch[i] = clip(yk[i] - gu[i] - gv[i]);
            b_ch[i] = clip(yk[i] + bu[i]);
        end
    end

    // Stage 1, all products
    always_ff @(posedge CLOCK_50_I) begin
        for (int i = 0; i < 2; i++) begin
            yk[i] <= `K_Y * y_c[i];
            rv[i] <= `K_RV * v_c[i];
            gu[i] <= `K_GU * u_c[i];
            gv[i] <= `K_GV * v_c[i];
            bu[i] <= `K_BU * u_c[i];
        end
    end

    // Stage 2, sums and clipping into the channel view
    always_ff @(posedge CLOCK_50_I) begin
        if (valid1) begin
            pair_in.pix.r0 <= r_ch[0];
            pair_in.pix.g0 <= g_ch[0];
            pair_in.pix.b0 <= b_ch[0];
            pair_in.pix.r1 <= r_ch[1];
            pair_in.pix.g1 <= g_ch[1];
            pair_in.pix.b1 <= b_ch[1];
        end
    end

    always_ff @(posedge CLOCK_50_I or negedge resetn) begin
        if (!resetn) begin
            valid1 <= 1'b0;
            push   <= 1'b0;
        end else begin
            valid1 <= up_valid;
            push   <= valid1;
        end
    end

endmodule

`default_nettype wire

// File: design/pair_fifo.sv
`timescale 1ns/1ns
`default_nettype none

`include "csc_cfg.svh"

module pair_fifo
    import csc_pkg::*;
(
    input  logic      CLOCK_50_I,
    input  logic      resetn,
    input  logic      push,
    input  rgb_pair_u pair_in,
    input  logic      pop,
    output rgb_pair_u pair_out,
    output logic      empty,
    output logic      full
);

    localparam int PTR_W = $clog2(`FIFO_DEPTH);
    // Up to six pairs may still arrive once the source stops:
    // three in the chroma window and three in pipeline registers
    localparam int FULL_LEVEL = `FIFO_DEPTH - 6;

    rgb_pair_u        mem [`FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             wr_en;
    logic             rd_en;

    assign wr_en    = push && (count != `FIFO_DEPTH);
    assign rd_en    = pop && !empty;
    assign empty    = (count == '0);
    assign full     = (count >= FULL_LEVEL);
    assign pair_out = mem[rd_ptr]; // First word falls through

    always_ff @(posedge CLOCK_50_I) begin
        if (wr_en) begin
            mem[wr_ptr] <= pair_in;
        end
    end

    always_ff @(posedge CLOCK_50_I or negedge resetn) begin
        if (!resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) wr_ptr <= wr_ptr + 1'b1; // Wraps at depth
            if (rd_en) rd_ptr <= rd_ptr + 1'b1;
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/rgb_word_packer.sv
`timescale 1ns/1ns
`default_nettype none

`include "csc_cfg.svh"

module rgb_word_packer
    import csc_pkg::*;
(
    input  logic               CLOCK_50_I,
    input  logic               resetn,
    input  logic               empty,
    input  rgb_pair_u          pair_out,
    output logic               pop,
    output logic               sram_we_n,
    output logic [`ADDR_W-1:0] sram_address,
    output logic [`WORD_W-1:0] sram_write_data
);

    rgb_pair_u          hold;
    logic [1:0]         word_sel;  // Words of the held pair still to write
    logic [`ADDR_W-1:0] word_addr;

    // Next pair may start right after the last word
    assign pop = !empty && (word_sel == 2'd0);

    always_ff @(posedge CLOCK_50_I or negedge resetn) begin
        if (!resetn) begin
            word_sel     <= 2'd0;
            sram_we_n    <= 1'b1;
            sram_address <= `RGB_BASE;
            word_addr    <= `RGB_BASE;
        end else if (pop || word_sel != 2'd0) begin
            word_sel     <= pop ? 2'd2 : word_sel - 2'd1;
            sram_we_n    <= 1'b0;
            sram_address <= word_addr;
            word_addr    <= word_addr + 1'b1;
        end else begin
            sram_we_n <= 1'b1;
        end
    end

    always_ff @(posedge CLOCK_50_I) begin
        if (pop) begin
            hold            <= pair_out;
            sram_write_data <= pair_out.words[2]; // {R0,G0}
        end else if (word_sel != 2'd0) begin
            sram_write_data <= hold.words[word_sel - 2'd1];
        end
    end

endmodule

`default_nettype wire

// File: design/csc_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "csc_cfg.svh"

module csc_top
    import csc_pkg::*;
(
    input  logic                   CLOCK_50_I,
    input  logic                   resetn,
    input  logic                   pair_strobe,
    input  logic                   line_first,
    input  logic                   line_last,
    input  logic [2*`SAMPLE_W-1:0] y_pair,
    input  logic [`SAMPLE_W-1:0]   u_sample,
    input  logic [`SAMPLE_W-1:0]   v_sample,
    output logic                   sram_we_n,
    output logic [`ADDR_W-1:0]     sram_address,
    output logic [`WORD_W-1:0]     sram_write_data,
    output logic                   pair_fifo_full
);

    // Upsampler to converter
    logic                     up_valid;
    logic [`SAMPLE_W-1:0]     y_even;
    logic [`SAMPLE_W-1:0]     y_odd;
    logic [`SAMPLE_W-1:0]     u_even;
    logic signed [`ACC_W-1:0] u_odd;
    logic [`SAMPLE_W-1:0]     v_even;
    logic signed [`ACC_W-1:0] v_odd;

    logic      push;
    logic      pop;
    logic      empty;
    rgb_pair_u pair_in;
    rgb_pair_u pair_out;

    chroma_upsampler chroma_upsampler_inst (
        .CLOCK_50_I (CLOCK_50_I),
        .resetn     (resetn),
        .pair_strobe(pair_strobe),
        .line_first (line_first),
        .line_last  (line_last),
        .y_pair     (y_pair),
        .u_sample   (u_sample),
        .v_sample   (v_sample),
        .up_valid   (up_valid),
        .y_even     (y_even),
        .y_odd      (y_odd),
        .u_even     (u_even),
        .u_odd      (u_odd),
        .v_even     (v_even),
        .v_odd      (v_odd)
    );

    yuv_to_rgb yuv_to_rgb_inst (
        .CLOCK_50_I(CLOCK_50_I),
        .resetn    (resetn),
        .up_valid  (up_valid),
        .y_even    (y_even),
        .y_odd     (y_odd),
        .u_even    (u_even),
        .u_odd     (u_odd),
        .v_even    (v_even),
        .v_odd     (v_odd),
        .push      (push),
        .pair_in   (pair_in)
    );

    pair_fifo pair_fifo_inst (
        .CLOCK_50_I(CLOCK_50_I),
        .resetn    (resetn),
        .push      (push),
        .pair_in   (pair_in),
        .pop       (pop),
        .pair_out  (pair_out),
        .empty     (empty),
        .full      (pair_fifo_full)
    );

    rgb_word_packer rgb_word_packer_inst (
        .CLOCK_50_I     (CLOCK_50_I),
        .resetn         (resetn),
        .empty          (empty),
        .pair_out       (pair_out),
        .pop            (pop),
        .sram_we_n      (sram_we_n),
        .sram_address   (sram_address),
        .sram_write_data(sram_write_data)
    );

endmodule

`default_nettype wire

// File: verif/csc_assert.sv
`timescale 1ns/1ns
`default_nettype none

`include "csc_cfg.svh"

module csc_assert (
    input logic                         CLOCK_50_I,
    input logic                         resetn,
    input logic                         push,
    input logic                         pop,
    input logic [$clog2(`FIFO_DEPTH):0] fifo_count,
    input logic                         sram_we_n
);

    // A push into a completely full buffer would be dropped
    no_overflow: assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
        push |-> fifo_count != `FIFO_DEPTH)
        else $error("pair FIFO pushed while holding %0d pairs", fifo_count);

    // Each popped pair becomes three back-to-back SRAM writes
    three_words_per_pop: assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
        pop |=> !sram_we_n ##1 !sram_we_n ##1 !sram_we_n)
        else $error("pair pop not followed by three SRAM writes");

    // Write strobe stays inactive through reset
    we_idle_in_reset: assert property (@(posedge CLOCK_50_I)
        !resetn |=> sram_we_n)
        else $error("sram_we_n low during reset");

endmodule

`default_nettype wire

// File: verif/csc_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "csc_cfg.svh"

module csc_tb;

    localparam int NUM_LINES = 20;
    localparam int MAX_PAIRS = 12;

    logic                   CLOCK_50_I;
    logic                   resetn;
    logic                   pair_strobe;
    logic                   line_first;
    logic                   line_last;
    logic [2*`SAMPLE_W-1:0] y_pair;
    logic [`SAMPLE_W-1:0]   u_sample;
    logic [`SAMPLE_W-1:0]   v_sample;
    logic                   sram_we_n;
    logic [`ADDR_W-1:0]     sram_address;
    logic [`WORD_W-1:0]     sram_write_data;
    logic                   pair_fifo_full;

    logic [31:0]            rng_state;
    int                     line_len [NUM_LINES];
    logic [2*`SAMPLE_W-1:0] line_y [MAX_PAIRS];   // Even pixel in the upper byte
    logic [`SAMPLE_W-1:0]   line_u [MAX_PAIRS];
    logic [`SAMPLE_W-1:0]   line_v [MAX_PAIRS];
    logic [`ADDR_W-1:0]     exp_addr [$];
    logic [`WORD_W-1:0]     exp_data [$];
    logic [`ADDR_W-1:0]     next_addr;
    logic                   full_seen;
    int                     total_pairs;
    int                     cycle_count;
    int                     cycle_limit;

    csc_top csc_top_inst (
        .CLOCK_50_I     (CLOCK_50_I),
        .resetn         (resetn),
        .pair_strobe    (pair_strobe),
        .line_first     (line_first),
        .line_last      (line_last),
        .y_pair         (y_pair),
        .u_sample       (u_sample),
        .v_sample       (v_sample),
        .sram_we_n      (sram_we_n),
        .sram_address   (sram_address),
        .sram_write_data(sram_write_data),
        .pair_fifo_full (pair_fifo_full)
    );

    bind csc_top csc_assert csc_assert_inst (
        .CLOCK_50_I(CLOCK_50_I),
        .resetn    (resetn),
        .push      (push),
        .pop       (pop),
        .fifo_count(pair_fifo_inst.count),
        .sram_we_n (sram_we_n)
    );

    always #2 CLOCK_50_I = ~CLOCK_50_I;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // One in eight samples sits at a rail to force saturation
    function automatic logic [`SAMPLE_W-1:0] pick_sample();
        logic [31:0] r;
        r = next_rand();
        if (r[2:0] == 3'd0) begin
            return r[3] ? 8'hff : 8'h00;
        end
        return r[15:8];
    endfunction

    // Line edges repeat the first or last chroma sample
    function automatic int chroma_at(input bit is_v, input int idx, input int n);
        int k;
        k = (idx < 0) ? 0 : ((idx > n - 1) ? n - 1 : idx);
        return is_v ? int'(line_v[k]) : int'(line_u[k]);
    endfunction

    function automatic int interp_odd(input bit is_v, input int j, input int n);
        int acc;
        acc = `FIR_C0 * chroma_at(is_v, j - 2, n) - `FIR_C1 * chroma_at(is_v, j - 1, n)
            + `FIR_C2 * chroma_at(is_v, j, n) + `FIR_C2 * chroma_at(is_v, j + 1, n)
            - `FIR_C1 * chroma_at(is_v, j + 2, n) + `FIR_C0 * chroma_at(is_v, j + 3, n)
            + `FIR_ROUND;
        return acc >>> `FIR_SHIFT;
    endfunction

    function automatic logic [`SAMPLE_W-1:0] clip_channel(input int s);
        if (s < 0) begin
            return 8'd0;
        end
        if (s >= (1 << (`RGB_SHIFT + `SAMPLE_W))) begin
            return 8'd255;
        end
        return (s >> `RGB_SHIFT) & 8'hff;
    endfunction

    // Returns {R, G, B} for one pixel
    function automatic logic [3*`SAMPLE_W-1:0] pixel_rgb(input int y, input int u, input int v);
        int yk;
        int r;
        int g;
        int b;
        yk = `K_Y * (y - `Y_OFFSET);
        r  = yk + `K_RV * (v - `C_OFFSET);
        g  = yk - `K_GU * (u - `C_OFFSET) - `K_GV * (v - `C_OFFSET);
        b  = yk + `K_BU * (u - `C_OFFSET);
        return {clip_channel(r), clip_channel(g), clip_channel(b)};
    endfunction

    task automatic expect_word(input logic [`WORD_W-1:0] w);
        exp_addr.push_back(next_addr);
        exp_data.push_back(w);
        next_addr = next_addr + 1'b1;
    endtask

    task automatic queue_line(input int n);
        logic [23:0] p0;
        logic [23:0] p1;
        for (int j = 0; j < n; j++) begin
            p0 = pixel_rgb(line_y[j][15:8], line_u[j], line_v[j]);
            p1 = pixel_rgb(line_y[j][7:0], interp_odd(0, j, n), interp_odd(1, j, n));
            expect_word({p0[23:16], p0[15:8]}); // {R0,G0}
            expect_word({p0[7:0], p1[23:16]});  // {B0,R1}
            expect_word({p1[15:8], p1[7:0]});   // {G1,B1}
        end
    endtask

    task automatic send_pair(input logic first, input logic last, input int j);
        @(posedge CLOCK_50_I);
        while (pair_fifo_full) begin
            pair_strobe <= 1'b0;
            @(posedge CLOCK_50_I);
        end
        pair_strobe <= 1'b1;
        line_first  <= first;
        line_last   <= last;
        y_pair      <= line_y[j];
        u_sample    <= line_u[j];
        v_sample    <= line_v[j];
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge CLOCK_50_I);
            pair_strobe <= 1'b0;
            line_first  <= 1'b0;
            line_last   <= 1'b0;
        end
    endtask

    task automatic stop_with_failure();
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped on the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: %s got 0x%0h expected 0x%0h", name, got, exp);
            stop_with_failure();
        end
    endtask

    // Every written word must match the head of the expected queue
    always @(posedge CLOCK_50_I) begin
        if (resetn && !sram_we_n) begin
            if (exp_data.size() == 0) begin
                $display("SRAM write at address 0x%0h with no word left to expect",
                         sram_address);
                stop_with_failure();
            end else begin
                check_value("sram_address", sram_address, exp_addr.pop_front());
                check_value("sram_write_data", sram_write_data, exp_data.pop_front());
            end
        end
    end

    // Four pushes in a row at each line end fill past the full level
    always @(posedge CLOCK_50_I) begin
        if (resetn && pair_fifo_full) begin
            full_seen <= 1'b1;
        end
    end

    always @(posedge CLOCK_50_I) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles with %0d words still expected",
                     cycle_count, exp_data.size());
            stop_with_failure();
        end
    end

    initial begin
        logic [31:0] r;
        logic        burst;
        int          n;
        CLOCK_50_I  = 1'b0;
        resetn      = 1'b0;
        pair_strobe = 1'b0;
        line_first  = 1'b0;
        line_last   = 1'b0;
        y_pair      = '0;
        u_sample    = '0;
        v_sample    = '0;
        rng_state   = 32'ha76b_d1f5;
        next_addr   = `RGB_BASE;
        full_seen   = 1'b0;
        cycle_count = 0;
        total_pairs = 0;
        for (int i = 0; i < NUM_LINES; i++) begin
            line_len[i] = `MIN_LINE_PAIRS + int'(next_rand() % 9); // 4 to 12 pairs
            total_pairs += line_len[i];
        end
        cycle_limit = total_pairs * 3 + NUM_LINES * 8 + 100;

        repeat (3) @(posedge CLOCK_50_I);
        resetn <= 1'b1;
        @(posedge CLOCK_50_I);
        check_value("pair_fifo_full", pair_fifo_full, 1'b0);

        for (int i = 0; i < NUM_LINES; i++) begin
            n     = line_len[i];
            r     = next_rand();
            burst = r[0];  // Back-to-back pairs lean on the full level
            for (int j = 0; j < n; j++) begin
                line_y[j] = {pick_sample(), pick_sample()};
                line_u[j] = pick_sample();
                line_v[j] = pick_sample();
            end
            queue_line(n);
            for (int j = 0; j < n; j++) begin
                send_pair(j == 0, j == n - 1, j);
                r = next_rand();
                if (!burst && j != n - 1 && r[1:0] == 2'd0) begin
                    idle_cycles(int'(r[3:2]) % 3);
                end
            end
            idle_cycles(3 + int'(r[5:4])); // Flush window, then a short gap
        end

        while (exp_data.size() != 0) begin
            @(posedge CLOCK_50_I);
        end
        repeat (10) @(posedge CLOCK_50_I);
        check_value("pair_fifo_full", pair_fifo_full, 1'b0); // Drained buffer
        if (!full_seen) begin
            $display("pair_fifo_full never went high while the lines were sent");
            stop_with_failure();
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+design
design/csc_pkg.sv
design/chroma_upsampler.sv
design/yuv_to_rgb.sv
design/pair_fifo.sv
design/rgb_word_packer.sv
design/csc_top.sv
verif/csc_assert.sv
verif/csc_tb.sv
